/* all.f */
+incdir+bench
hw/fei4_rx_pkg.sv
hw/rx_symbol_if.sv
hw/rx_sync_fsm.sv
hw/rx_bit_counter.sv
hw/dec_8b10b.sv
hw/rx_frame_fifo.sv
hw/receiver_logic.sv
hw/fei4_rx_core.sv
bench/tb_fei4_rx.sv

/* bench/tb_encoder.svh */
//--------------------------------------------------
// 8b10b encoder with running disparity
// and serial send task for the RX line
//--------------------------------------------------
`ifndef TB_ENCODER_SVH
`define TB_ENCODER_SVH

    // 5b/6b codes for RD-, entry 0 in the low bits
    localparam logic [191:0] TBL6 = {
        6'b101011, 6'b011110, 6'b101110, 6'b001110, 6'b110110, 6'b010110, 6'b100110, 6'b110011,
        6'b111010, 6'b011010, 6'b101010, 6'b001011, 6'b110010, 6'b010011, 6'b100011, 6'b011011,
        6'b010111, 6'b011100, 6'b101100, 6'b001101, 6'b110100, 6'b010101, 6'b100101, 6'b111001,
        6'b111000, 6'b011001, 6'b101001, 6'b110101, 6'b110001, 6'b101101, 6'b011101, 6'b100111
    };
    localparam logic [31:0] TBL4   = {4'b1110, 4'b0110, 4'b1010, 4'b1101,
                                      4'b1100, 4'b0101, 4'b1001, 4'b1011};
    localparam logic [31:0] K28_4B = {4'b1000, 4'b0110, 4'b1010, 4'b0010,
                                      4'b0011, 4'b0101, 4'b1001, 4'b0100};
    localparam logic [9:0]  BAD_SYMBOL = 10'b1111000011;   // 6b part not in any table

    logic line_rd     = 1'b0;   // running disparity, 0 is RD-
    logic line_invert = 1'b0;

    function automatic logic [9:0] encode_char(input logic [7:0] b, input logic k);
        logic [5:0] c6;
        logic [3:0] c4;
        logic       rd6;
        if (k) begin
            c6 = line_rd ? 6'b110000 : 6'b001111;
            c4 = line_rd ? ~K28_4B[b[7:5]*4 +: 4] : K28_4B[b[7:5]*4 +: 4];
        end else begin
            c6 = TBL6[b[4:0]*6 +: 6];
            if (line_rd && ($countones(c6) != 3 || c6 == 6'b111000))
                c6 = ~c6;
            rd6 = line_rd ^ ($countones(c6) != 3);
            c4 = TBL4[b[7:5]*4 +: 4];
            if (rd6 && ($countones(c4) != 2 || c4 == 4'b1100))
                c4 = ~c4;
        end
        line_rd = line_rd ^ ($countones({c6, c4}) != 5);   // unbalanced symbols flip RD
        return {c6, c4};
    endfunction

    // item bit 9 marks an invalid symbol, bit 8 the K flag
    task automatic send_item(input logic [9:0] item);
        logic [9:0] code;
        if (item[9])
            code = BAD_SYMBOL;
        else
            code = encode_char(item[7:0], item[8]);
        for (int i = 9; i >= 0; i--) begin
            @(posedge BUS_CLK);
            RX_DATA <= code[i] ^ line_invert;   // bit a goes first
        end
    endtask

`endif

/* bench/tb_fei4_rx.sv */
//--------------------------------------------------
// testbench of the FE-I4 receiver
// serial line driver, bus and FIFO tasks,
// six tests with checks and report
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_fei4_rx;

    localparam logic [7:0] DATA_ID      = 8'hA5;
    localparam int         FIFO_DEPTH   = 16;
    localparam int         STIM_SYMBOLS = 1000;   // rough sum over all tests, bus gaps included
    localparam int         MAX_CYCLES   = 2 * 10 * STIM_SYMBOLS;

    logic        BUS_CLK;
    logic        RST;
    logic        RX_DATA;
    logic        FIFO_READ;
    logic [15:0] BUS_ADD;
    logic [7:0]  BUS_DATA_IN;
    logic        BUS_WR;
    logic        BUS_RD;
    wire         RX_READY;
    wire         RX_8B10B_DECODER_ERR;
    wire         RX_FIFO_OVERFLOW_ERR;
    wire         RX_FIFO_FULL;
    wire         FIFO_EMPTY;
    wire  [31:0] FIFO_DATA;
    wire  [7:0]  BUS_DATA_OUT;

    int          seed = 10;
    int          cycles = 0;
    int          errors = 0;
    int          test_start = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          sym_count = 0;
    bit          tx_on = 1'b0;
    logic [9:0]  tx_q[$];
    logic [31:0] exp_q[$];

    `include "tb_encoder.svh"

    fei4_rx_core #(
        .DATA_IDENTIFIER (DATA_ID),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) i_fei4_rx_core (
        .RX_DATA(RX_DATA), .RX_READY(RX_READY),
        .RX_8B10B_DECODER_ERR(RX_8B10B_DECODER_ERR), .RX_FIFO_OVERFLOW_ERR(RX_FIFO_OVERFLOW_ERR),
        .RX_FIFO_FULL(RX_FIFO_FULL), .FIFO_READ(FIFO_READ), .FIFO_EMPTY(FIFO_EMPTY),
        .FIFO_DATA(FIFO_DATA), .BUS_CLK(BUS_CLK), .RST(RST), .BUS_ADD(BUS_ADD),
        .BUS_DATA_IN(BUS_DATA_IN), .BUS_WR(BUS_WR), .BUS_RD(BUS_RD), .BUS_DATA_OUT(BUS_DATA_OUT)
    );

    initial BUS_CLK = 1'b0;
    always #50 BUS_CLK = ~BUS_CLK;

    always @(posedge BUS_CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped, no end after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // line driver, commas whenever nothing is queued
    initial begin : line_driver
        logic [9:0] item;
        forever begin
            if (!tx_on) begin
                @(posedge BUS_CLK);
                RX_DATA <= 1'b0;
            end else begin
                if (tx_q.size() > 0)
                    item = tx_q.pop_front();
                else
                    item = {2'b01, fei4_rx_pkg::K28_5};
                sym_count++;
                send_item(item);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start) begin
            $display("PASS %s", name);
            pass_cnt++;
        end else begin
            $display("FAIL %s", name);
            fail_cnt++;
        end
        test_start = errors;
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD     <= {8'd0, addr};
        BUS_DATA_IN <= data;
        BUS_WR      <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    task automatic bus_read_check(input logic [7:0] addr, input logic [7:0] exp,
                                  input string name);
        @(posedge BUS_CLK);
        BUS_ADD <= {8'd0, addr};
        BUS_RD  <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD <= 1'b0;
        @(negedge BUS_CLK);
        check_value(name, BUS_DATA_OUT, exp);
    endtask

    task automatic wait_ready(input logic level, input int limit);
        int n;
        fei4_rx_pkg::sync_state_t st;
        n = 0;
        while (RX_READY !== level && n < limit) begin
            @(negedge BUS_CLK);
            n++;
        end
        st = i_fei4_rx_core.i_receiver_logic.i_rx_sync_fsm.state;
        check_cond(RX_READY === level, $sformatf("RX_READY did not reach %0b in %0d cycles, state %s",
                   level, limit, st.name()));
    endtask

    // SOF, bytes with bad symbols after the first n_bad bytes, EOF, comma
    task automatic queue_frame(input int n_bytes, input int n_bad);
        logic [7:0]  b;
        logic [23:0] word;
        tx_q.push_back({2'b01, fei4_rx_pkg::K28_7});
        for (int i = 0; i < n_bytes; i++) begin
            b = 8'($random(seed));
            tx_q.push_back({2'b00, b});
            if (i < n_bad)
                tx_q.push_back({2'b10, 8'h00});
            word = {word[15:0], b};    // first byte ends up on top
            if (i % 3 == 2)
                exp_q.push_back({DATA_ID, word});
        end
        tx_q.push_back({2'b01, fei4_rx_pkg::K28_3});
        tx_q.push_back({2'b01, fei4_rx_pkg::K28_5});
    endtask

    // queue drained and two more symbols fully on the line
    task automatic wait_line_idle();
        int start;
        while (tx_q.size() != 0)
            @(posedge BUS_CLK);
        start = sym_count;
        while (sym_count < start + 2)
            @(posedge BUS_CLK);
        @(negedge BUS_CLK);
    endtask

    task automatic pop_words();
        logic [31:0] exp;
        int          n;
        @(negedge BUS_CLK);
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            n = 0;
            while (FIFO_EMPTY && n < 200) begin
                @(negedge BUS_CLK);
                n++;
            end
            check_cond(!FIFO_EMPTY, $sformatf("FIFO stayed empty, word %h expected", exp));
            check_value("FIFO_DATA", FIFO_DATA, exp);
            @(posedge BUS_CLK);
            FIFO_READ <= 1'b1;
            @(posedge BUS_CLK);
            FIFO_READ <= 1'b0;
            @(negedge BUS_CLK);
        end
        check_value("FIFO_EMPTY", FIFO_EMPTY, 1'b1);
    endtask

    initial begin
        RST         = 1'b1;
        RX_DATA     = 1'b0;
        FIFO_READ   = 1'b0;
        BUS_ADD     = 16'd0;
        BUS_DATA_IN = 8'd0;
        BUS_WR      = 1'b0;
        BUS_RD      = 1'b0;
        repeat (4) @(posedge BUS_CLK);
        RST <= 1'b0;
        @(negedge BUS_CLK);

        check_value("RX_READY", RX_READY, 1'b0);
        check_value("RX_FIFO_FULL", RX_FIFO_FULL, 1'b0);
        check_value("RX_8B10B_DECODER_ERR", RX_8B10B_DECODER_ERR, 1'b0);
        check_value("RX_FIFO_OVERFLOW_ERR", RX_FIFO_OVERFLOW_ERR, 1'b0);
        check_value("FIFO_EMPTY", FIFO_EMPTY, 1'b1);
        bus_read_check(fei4_rx_pkg::ADDR_RESET, fei4_rx_pkg::VERSION, "version");
        bus_read_check(fei4_rx_pkg::ADDR_DEC_ERR, 8'd0, "decoder errors");
        bus_read_check(fei4_rx_pkg::ADDR_LOST_ERR, 8'd0, "lost words");
        finish_test("after reset");

        repeat (5) @(posedge BUS_CLK);    // padding bits of zero
        tx_on = 1'b1;
        wait_ready(1'b1, 500);
        check_cond(sym_count >= fei4_rx_pkg::LOCK_COMMAS + 1, "lock with too few commas sent");
        bus_read_check(fei4_rx_pkg::ADDR_CONFIG, 8'h01, "config");
        finish_test("lock");

        for (int f = 0; f < 3; f++)
            queue_frame(6, 0);
        wait_line_idle();
        bus_read_check(fei4_rx_pkg::ADDR_SIZE_LO, 8'd6, "size low");
        bus_read_check(fei4_rx_pkg::ADDR_SIZE_HI, 8'd0, "size high");
        pop_words();
        check_value("RX_8B10B_DECODER_ERR", RX_8B10B_DECODER_ERR, 1'b0);
        finish_test("frames");

        bus_write(fei4_rx_pkg::ADDR_CONFIG, 8'h02);
        line_invert = 1'b1;
        bus_write(fei4_rx_pkg::ADDR_RX_RESET, 8'h00);    // relock on the inverted line
        wait_ready(1'b0, 20);
        wait_ready(1'b1, 500);
        bus_read_check(fei4_rx_pkg::ADDR_CONFIG, 8'h03, "config");
        queue_frame(6, 0);
        wait_line_idle();
        pop_words();
        bus_read_check(fei4_rx_pkg::ADDR_DEC_ERR, 8'd0, "decoder errors");
        finish_test("inversion");

        queue_frame(6, 3);
        wait_line_idle();
        check_value("RX_READY", RX_READY, 1'b1);
        check_value("RX_8B10B_DECODER_ERR", RX_8B10B_DECODER_ERR, 1'b1);
        bus_read_check(fei4_rx_pkg::ADDR_DEC_ERR, 8'd3, "decoder errors");
        pop_words();
        finish_test("decoder errors");

        queue_frame(3 * (FIFO_DEPTH + 3), 0);
        exp_q.delete();    // not popped
        wait_line_idle();
        check_value("RX_FIFO_FULL", RX_FIFO_FULL, 1'b1);
        check_value("RX_FIFO_OVERFLOW_ERR", RX_FIFO_OVERFLOW_ERR, 1'b1);
        bus_read_check(fei4_rx_pkg::ADDR_LOST_ERR, 8'd3, "lost words");
        bus_read_check(fei4_rx_pkg::ADDR_SIZE_LO, 8'(FIFO_DEPTH), "size low");
        tx_on = 1'b0;    // idle line, nothing to relock on
        bus_write(fei4_rx_pkg::ADDR_RESET, 8'h00);
        repeat (3) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        check_value("RX_READY", RX_READY, 1'b0);
        check_value("RX_FIFO_FULL", RX_FIFO_FULL, 1'b0);
        check_value("FIFO_EMPTY", FIFO_EMPTY, 1'b1);
        check_value("RX_FIFO_OVERFLOW_ERR", RX_FIFO_OVERFLOW_ERR, 1'b0);
        bus_read_check(fei4_rx_pkg::ADDR_CONFIG, 8'h00, "config");
        bus_read_check(fei4_rx_pkg::ADDR_LOST_ERR, 8'd0, "lost words");
        bus_read_check(fei4_rx_pkg::ADDR_DEC_ERR, 8'd0, "decoder errors");
        finish_test("overflow and reset");

        $display("tests passed %0d, failed %0d, failed checks %0d", pass_cnt, fail_cnt, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/dec_8b10b.sv */
//--------------------------------------------------
// 8b10b table decoder
// 6b/5b and 4b/3b lookup for both disparities,
// K28 detection and code error flag
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dec_8b10b (
    input  wire       BUS_CLK,
    input  wire       reset,
    input  wire [9:0] symbol,
    input  wire       sym_strobe,
    input  wire       locked,
    rx_symbol_if.dec  sym
);

    logic [5:0] code6;
    logic [3:0] code4;
    logic [3:0] code4_k;
    logic [4:0] dec5;
    logic [2:0] dec3;
    logic       is_k28;
    logic       err6;
    logic       err4;

    assign code6 = symbol[9:4];    // abcdei
    assign code4 = symbol[3:0];    // fghj
    assign is_k28 = (code6 == 6'b001111) || (code6 == 6'b110000);
    // K28 on the positive side uses the complement of the 4b part
    assign code4_k = (code6 == 6'b110000) ? ~code4 : code4;

    always_comb begin
        err6 = 1'b0;
        case (code6)
            6'b100111, 6'b011000: dec5 = 5'd0;
            6'b011101, 6'b100010: dec5 = 5'd1;
            6'b101101, 6'b010010: dec5 = 5'd2;
            6'b110001:            dec5 = 5'd3;
            6'b110101, 6'b001010: dec5 = 5'd4;
            6'b101001:            dec5 = 5'd5;
            6'b011001:            dec5 = 5'd6;
            6'b111000, 6'b000111: dec5 = 5'd7;
            6'b111001, 6'b000110: dec5 = 5'd8;
            6'b100101:            dec5 = 5'd9;
            6'b010101:            dec5 = 5'd10;
            6'b110100:            dec5 = 5'd11;
            6'b001101:            dec5 = 5'd12;
            6'b101100:            dec5 = 5'd13;
            6'b011100:            dec5 = 5'd14;
            6'b010111, 6'b101000: dec5 = 5'd15;
            6'b011011, 6'b100100: dec5 = 5'd16;
            6'b100011:            dec5 = 5'd17;
            6'b010011:            dec5 = 5'd18;
            6'b110010:            dec5 = 5'd19;
            6'b001011:            dec5 = 5'd20;
            6'b101010:            dec5 = 5'd21;
            6'b011010:            dec5 = 5'd22;
            6'b111010, 6'b000101: dec5 = 5'd23;
            6'b110011, 6'b001100: dec5 = 5'd24;
            6'b100110:            dec5 = 5'd25;
            6'b010110:            dec5 = 5'd26;
            6'b110110, 6'b001001: dec5 = 5'd27;
            6'b001110:            dec5 = 5'd28;
            6'b001111, 6'b110000: dec5 = 5'd28;    // K28
            6'b101110, 6'b010001: dec5 = 5'd29;
            6'b011110, 6'b100001: dec5 = 5'd30;
            6'b101011, 6'b010100: dec5 = 5'd31;
            default: begin
                dec5 = 5'd0;
                err6 = 1'b1;
            end
        endcase
    end

    always_comb begin
        err4 = 1'b0;
        if (is_k28) begin
            case (code4_k)
                4'b0100: dec3 = 3'd0;
                4'b1001: dec3 = 3'd1;
                4'b0101: dec3 = 3'd2;
                4'b0011: dec3 = 3'd3;
                4'b0010: dec3 = 3'd4;
                4'b1010: dec3 = 3'd5;
                4'b0110: dec3 = 3'd6;
                4'b1000: dec3 = 3'd7;
                default: begin
                    dec3 = 3'd0;
                    err4 = 1'b1;
                end
            endcase
        end else begin
            case (code4)
                4'b1011, 4'b0100:                   dec3 = 3'd0;
                4'b1001:                            dec3 = 3'd1;
                4'b0101:                            dec3 = 3'd2;
                4'b1100, 4'b0011:                   dec3 = 3'd3;
                4'b1101, 4'b0010:                   dec3 = 3'd4;
                4'b1010:                            dec3 = 3'd5;
                4'b0110:                            dec3 = 3'd6;
                4'b1110, 4'b0001, 4'b0111, 4'b1000: dec3 = 3'd7;   // primary and alternate
                default: begin
                    dec3 = 3'd0;
                    err4 = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            sym.sym_valid <= 1'b0;
            sym.is_k      <= 1'b0;
            sym.code_err  <= 1'b0;
        end else begin
            sym.sym_valid <= sym_strobe && locked;
            if (sym_strobe) begin
                sym.is_k     <= is_k28;
                sym.code_err <= err6 || err4;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (sym_strobe)
            sym.data <= {dec3, dec5};
    end

endmodule

`default_nettype wire

/* hw/fei4_rx_core.sv */
//--------------------------------------------------
// FE-I4 receiver top
// register bank, soft and receiver reset strobes,
// read-back mux and data header insertion
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fei4_rx_core #(
    parameter logic [7:0] DATA_IDENTIFIER = 8'd0,
    parameter int         FIFO_DEPTH      = 16,
    parameter int         ABUSWIDTH       = 16
) (
    input  wire                 RX_DATA,
    output logic                RX_READY,
    output logic                RX_8B10B_DECODER_ERR,
    output logic                RX_FIFO_OVERFLOW_ERR,
    output logic                RX_FIFO_FULL,

    input  wire                 FIFO_READ,
    output logic                FIFO_EMPTY,
    output logic [31:0]         FIFO_DATA,

    input  wire                 BUS_CLK,
    input  wire                 RST,
    input  wire [ABUSWIDTH-1:0] BUS_ADD,
    input  wire [7:0]           BUS_DATA_IN,
    input  wire                 BUS_WR,
    input  wire                 BUS_RD,
    output logic [7:0]          BUS_DATA_OUT
);

    logic [7:0]  addr;
    logic        addr_ok;    // upper address bits all zero
    logic        soft_ff;
    logic        soft_ff2;
    logic        rx_ff;
    logic        rx_ff2;
    logic        sys_rst;
    logic        rx_rst;
    logic [7:0]  config_reg;  // bit 1 inverts RX data
    logic [7:0]  size_hi;
    logic        ready;
    logic [23:0] fe_data;
    logic [15:0] fifo_size;
    logic [7:0]  decoder_err_cnt;
    logic [7:0]  lost_err_cnt;

    assign addr    = BUS_ADD[7:0];
    assign addr_ok = (BUS_ADD >> 8) == '0;

    // write strobes go through two flops, rising edge gives the reset pulse
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            soft_ff  <= 1'b0;
            soft_ff2 <= 1'b0;
            rx_ff    <= 1'b0;
            rx_ff2   <= 1'b0;
        end else begin
            soft_ff  <= BUS_WR && addr_ok && addr == fei4_rx_pkg::ADDR_RESET;
            soft_ff2 <= soft_ff;
            rx_ff    <= BUS_WR && addr_ok && addr == fei4_rx_pkg::ADDR_RX_RESET;
            rx_ff2   <= rx_ff;
        end
    end

    assign sys_rst = RST || (soft_ff && !soft_ff2);
    assign rx_rst  = sys_rst || (rx_ff && !rx_ff2);    // keeps the config

    always_ff @(posedge BUS_CLK) begin
        if (sys_rst)
            config_reg <= 8'd0;
        else if (BUS_WR && addr_ok && addr == fei4_rx_pkg::ADDR_CONFIG)
            config_reg <= BUS_DATA_IN;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            BUS_DATA_OUT <= 8'd0;
        end else if (BUS_RD) begin
            if (!addr_ok) begin
                BUS_DATA_OUT <= 8'd0;
            end else begin
                case (addr)
                    fei4_rx_pkg::ADDR_RESET:    BUS_DATA_OUT <= fei4_rx_pkg::VERSION;
                    fei4_rx_pkg::ADDR_CONFIG:   BUS_DATA_OUT <= {config_reg[7:1], ready};
                    fei4_rx_pkg::ADDR_SIZE_LO:  BUS_DATA_OUT <= fifo_size[7:0];
                    fei4_rx_pkg::ADDR_SIZE_HI:  BUS_DATA_OUT <= size_hi;
                    fei4_rx_pkg::ADDR_DEC_ERR:  BUS_DATA_OUT <= decoder_err_cnt;
                    fei4_rx_pkg::ADDR_LOST_ERR: BUS_DATA_OUT <= lost_err_cnt;
                    default:                    BUS_DATA_OUT <= 8'd0;
                endcase
            end
        end
    end

    // high byte frozen when the low byte is read
    always_ff @(posedge BUS_CLK) begin
        if (RST)
            size_hi <= 8'd0;
        else if (BUS_RD && addr_ok && addr == fei4_rx_pkg::ADDR_SIZE_LO)
            size_hi <= fifo_size[15:8];
    end

    assign RX_READY             = ready;
    assign RX_8B10B_DECODER_ERR = (decoder_err_cnt != 8'd0);
    assign RX_FIFO_OVERFLOW_ERR = (lost_err_cnt != 8'd0);
    assign FIFO_DATA            = {DATA_IDENTIFIER, fe_data};

    receiver_logic #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_receiver_logic (
        .BUS_CLK         (BUS_CLK),
        .reset           (rx_rst),
        .rx_data         (RX_DATA),
        .invert          (config_reg[1]),
        .read            (FIFO_READ),
        .data            (fe_data),
        .empty           (FIFO_EMPTY),
        .full            (RX_FIFO_FULL),
        .ready           (ready),
        .fifo_size       (fifo_size),
        .decoder_err_cnt (decoder_err_cnt),
        .lost_err_cnt    (lost_err_cnt)
    );

endmodule

`default_nettype wire

/* hw/fei4_rx_pkg.sv */
//--------------------------------------------------
// shared definitions of the FE-I4 8b10b receiver
// lock states, register map, control symbols,
// comma patterns and version number
//--------------------------------------------------
`default_nettype none

package fei4_rx_pkg;

    typedef enum logic [1:0] {
        HUNT   = 2'd0,
        CHECK  = 2'd1,
        LOCKED = 2'd2
    } sync_state_t;

    // register map of the byte bus
    typedef enum logic [7:0] {
        ADDR_RESET    = 8'd0,   // version on read
        ADDR_RX_RESET = 8'd1,
        ADDR_CONFIG   = 8'd2,
        ADDR_SIZE_LO  = 8'd3,
        ADDR_SIZE_HI  = 8'd4,
        ADDR_DEC_ERR  = 8'd5,
        ADDR_LOST_ERR = 8'd6
    } reg_addr_t;

    localparam logic [7:0] K28_5 = 8'hBC;   // comma
    localparam logic [7:0] K28_7 = 8'hFC;   // start of frame
    localparam logic [7:0] K28_3 = 8'h7C;   // end of frame

    // abcdei fghj, bit a is first on the line and lands in bit 9
    localparam logic [9:0] COMMA_NEG = 10'b0011111010;
    localparam logic [9:0] COMMA_POS = 10'b1100000101;

    localparam int LOCK_COMMAS = 4;
    localparam logic [7:0] VERSION = 8'd2;

endpackage

`default_nettype wire

/* hw/receiver_logic.sv */
//--------------------------------------------------
// receive path of the FE-I4 link
// inversion, symbol shift register, comma detect,
// decoder error counter and receiver blocks
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module receiver_logic #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire         BUS_CLK,
    input  wire         reset,
    input  wire         rx_data,
    input  wire         invert,
    input  wire         read,
    output logic [23:0] data,
    output logic        empty,
    output logic        full,
    output logic        ready,
    output logic [15:0] fifo_size,
    output logic [7:0]  decoder_err_cnt,
    output logic [7:0]  lost_err_cnt
);

    logic [9:0] shift_reg;    // first bit ends up in bit 9
    logic       comma;
    logic       realign;
    logic       sym_strobe;
    logic       locked;

    rx_symbol_if sym ();

    always_ff @(posedge BUS_CLK) begin
        if (reset)
            shift_reg <= 10'd0;
        else
            shift_reg <= {shift_reg[8:0], rx_data ^ invert};
    end

    assign comma = (shift_reg == fei4_rx_pkg::COMMA_POS) ||
                   (shift_reg == fei4_rx_pkg::COMMA_NEG);

    // code errors in locked symbols only, saturating
    always_ff @(posedge BUS_CLK) begin
        if (reset)
            decoder_err_cnt <= 8'd0;
        else if (sym.sym_valid && sym.code_err && decoder_err_cnt != 8'hFF)
            decoder_err_cnt <= decoder_err_cnt + 8'd1;
    end

    assign ready = locked;

    rx_sync_fsm i_rx_sync_fsm (
        .BUS_CLK    (BUS_CLK),
        .reset      (reset),
        .comma      (comma),
        .sym_strobe (sym_strobe),
        .code_err   (sym.code_err),
        .realign    (realign),
        .locked     (locked)
    );

    rx_bit_counter i_rx_bit_counter (
        .BUS_CLK    (BUS_CLK),
        .reset      (reset),
        .realign    (realign),
        .sym_strobe (sym_strobe)
    );

    dec_8b10b i_dec_8b10b (
        .BUS_CLK    (BUS_CLK),
        .reset      (reset),
        .symbol     (shift_reg),
        .sym_strobe (sym_strobe),
        .locked     (locked),
        .sym        (sym.dec)
    );

    rx_frame_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_rx_frame_fifo (
        .BUS_CLK      (BUS_CLK),
        .reset        (reset),
        .sym          (sym.sink),
        .read         (read),
        .data         (data),
        .empty        (empty),
        .full         (full),
        .fifo_size    (fifo_size),
        .lost_err_cnt (lost_err_cnt)
    );

endmodule

`default_nettype wire

/* hw/rx_bit_counter.sv */
//--------------------------------------------------
// modulo-10 bit counter
// marks symbol boundaries, realigned on a comma
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rx_bit_counter (
    input  wire  BUS_CLK,
    input  wire  reset,
    input  wire  realign,
    output logic sym_strobe
);

    logic [3:0] bit_cnt;

    // count 9 means ten fresh bits in the shift register
    always_ff @(posedge BUS_CLK) begin
        if (reset)
            bit_cnt <= 4'd0;
        else if (realign || bit_cnt == 4'd9)
            bit_cnt <= 4'd0;    // realign makes the current content a full symbol
        else
            bit_cnt <= bit_cnt + 4'd1;
    end

    assign sym_strobe = (bit_cnt == 4'd9);

endmodule

`default_nettype wire

/* hw/rx_frame_fifo.sv */
//--------------------------------------------------
// frame byte packer and show-ahead word FIFO
// occupancy count and lost word counter
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rx_frame_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire         BUS_CLK,
    input  wire         reset,
    rx_symbol_if.sink   sym,
    input  wire         read,
    output logic [23:0] data,
    output logic        empty,
    output logic        full,
    output logic [15:0] fifo_size,
    output logic [7:0]  lost_err_cnt
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic          in_frame;
    logic [1:0]    byte_idx;
    logic [15:0]   partial;    // first two bytes of the word
    logic          good_sym;
    logic          push;
    logic          wr_en;
    logic          rd_en;
    logic [23:0]   mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    assign good_sym = sym.sym_valid && !sym.code_err;
    assign push  = good_sym && !sym.is_k && in_frame && byte_idx == 2'd2;
    assign wr_en = push && !full;
    assign rd_en = read && !empty;

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            in_frame <= 1'b0;
            byte_idx <= 2'd0;
        end else if (good_sym) begin
            if (sym.is_k) begin
                if (sym.data == fei4_rx_pkg::K28_7) begin
                    in_frame <= 1'b1;
                    byte_idx <= 2'd0;
                end else if (sym.data == fei4_rx_pkg::K28_3) begin
                    in_frame <= 1'b0;
                    byte_idx <= 2'd0;   // partial word dropped
                end
            end else if (in_frame) begin
                byte_idx <= (byte_idx == 2'd2) ? 2'd0 : byte_idx + 2'd1;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (good_sym && !sym.is_k && in_frame)
            partial <= {partial[7:0], sym.data};
        if (wr_en)
            mem[wr_ptr] <= {partial, sym.data};
    end

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            lost_err_cnt <= 8'd0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
            if (push && full && lost_err_cnt != 8'hFF)
                lost_err_cnt <= lost_err_cnt + 8'd1;
        end
    end

    assign data      = mem[rd_ptr];    // show-ahead
    assign empty     = (count == '0);
    assign full      = (count == (AW+1)'(FIFO_DEPTH));
    assign fifo_size = 16'(count);

endmodule

`default_nettype wire

/* hw/rx_symbol_if.sv */
//--------------------------------------------------
// decoded symbol from the 8b10b decoder
// to the frame packer and error counter
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface rx_symbol_if;

    logic       sym_valid;  // one cycle per locked symbol
    logic [7:0] data;
    logic       is_k;
    logic       code_err;

    modport dec (output sym_valid, data, is_k, code_err);
    modport sink (input sym_valid, data, is_k, code_err);

endinterface

`default_nettype wire

/* hw/rx_sync_fsm.sv */
//--------------------------------------------------
// comma search and lock FSM
// HUNT -> CHECK -> LOCKED, drops lock on
// code errors in two consecutive symbols
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rx_sync_fsm (
    input  wire  BUS_CLK,
    input  wire  reset,
    input  wire  comma,
    input  wire  sym_strobe,
    input  wire  code_err,    // held error flag of the previous symbol
    output logic realign,
    output logic locked
);

    localparam int CW = $clog2(fei4_rx_pkg::LOCK_COMMAS + 1);

    fei4_rx_pkg::sync_state_t state;
    logic [CW-1:0] comma_cnt;
    logic          err_prev;

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            state     <= fei4_rx_pkg::HUNT;
            comma_cnt <= '0;
            err_prev  <= 1'b0;
        end else begin
            case (state)
                fei4_rx_pkg::HUNT: begin
                    if (comma) begin
                        state     <= fei4_rx_pkg::CHECK;
                        comma_cnt <= CW'(1);    // the realigning comma counts
                    end
                end
                fei4_rx_pkg::CHECK: begin
                    if (sym_strobe) begin
                        if (!comma) begin
                            state <= fei4_rx_pkg::HUNT;
                        end else if (comma_cnt == CW'(fei4_rx_pkg::LOCK_COMMAS - 1)) begin
                            state    <= fei4_rx_pkg::LOCKED;
                            err_prev <= 1'b0;
                        end else begin
                            comma_cnt <= comma_cnt + 1'b1;
                        end
                    end else if (comma) begin
                        comma_cnt <= CW'(1);    // comma off the boundary, start over
                    end
                end
                fei4_rx_pkg::LOCKED: begin
                    if (sym_strobe) begin
                        err_prev <= code_err;
                        if (code_err && err_prev)
                            state <= fei4_rx_pkg::HUNT;
                    end
                end
                default: state <= fei4_rx_pkg::HUNT;
            endcase
        end
    end

    assign locked  = (state == fei4_rx_pkg::LOCKED);
    assign realign = comma && !locked;

endmodule

`default_nettype wire
